//--- filelist.f
ppu_pkg.sv
input_conditioning.sv
posit_to_fir.sv
fir_ops.sv
fir_to_posit.sv
ppu_core.sv
ppu_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module ppu_tb \
    -f filelist.f -o ppu_sim

status=0
./obj_dir/ppu_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

//--- ppu_tb.sv
// Posit unit testbench

`timescale 1ns/1ps

module ppu_tb import ppu_pkg::*; ();

    localparam int N            = 8;
    localparam int ES           = 0;
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 4;
    localparam int LATENCY      = 3;
    localparam int MAX_ROWS     = 64;
    localparam int NAR_ROWS     = 6;

    localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};

    logic         clk;
    logic         reset;
    logic [N-1:0] p1;
    logic [N-1:0] p2;
    ppu_op_e      op;
    logic         in_valid;
    logic [N-1:0] pout;
    logic         out_valid;

    // Stimulus table.
    logic [N-1:0] tab_p1   [MAX_ROWS];
    logic [N-1:0] tab_p2   [MAX_ROWS];
    ppu_op_e      tab_op   [MAX_ROWS];
    logic [N-1:0] tab_exp  [MAX_ROWS];
    string        tab_name [MAX_ROWS];
    int           num_rows = 0;

    // Operations in flight, oldest first.
    logic [N-1:0] exp_q[$];
    int           row_q[$];
    int           cycle_q[$];

    int           cycle        = 0;
    int           results_seen = 0;
    int           tests_passed = 0;
    int           tests_failed = 0;
    int           other_errors = 0;
    integer       seed;
    logic [N-1:0] exp_val;
    int           row_idx;
    int           in_cycle;
    logic         row_ok;

    ppu_core #(.N(N), .ES(ES)) u_ppu_core (
        .clk(clk), .reset(reset),
        .p1(p1), .p2(p2), .op(op), .in_valid(in_valid),
        .pout(pout), .out_valid(out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ----------------------------------------
    // Table construction
    // ----------------------------------------

    task automatic add_row(input logic [N-1:0] a, input logic [N-1:0] b,
                           input ppu_op_e o, input logic [N-1:0] expected,
                           input string name);
        tab_p1[num_rows]   = a;
        tab_p2[num_rows]   = b;
        tab_op[num_rows]   = o;
        tab_exp[num_rows]  = expected;
        tab_name[num_rows] = name;
        num_rows++;
    endtask

    // Posit8 es0 values: 0x40 is 1, 0x20 is 0.5, 0x60 is 2, 0x70 is 4.
    task automatic build_table();
        add_row(8'h40, 8'h40, OP_ADD, 8'h60, "1 + 1");
        add_row(8'h40, 8'h20, OP_ADD, 8'h50, "1 + 0.5");
        add_row(8'h60, 8'h60, OP_ADD, 8'h70, "2 + 2");
        add_row(8'h40, 8'h70, OP_ADD, 8'h72, "1 + 4");
        add_row(8'h40, 8'h40, OP_SUB, 8'h00, "1 - 1");
        add_row(8'h60, 8'h40, OP_SUB, 8'h40, "2 - 1");
        add_row(8'h40, 8'h60, OP_SUB, 8'hC0, "1 - 2");
        add_row(8'h60, 8'h20, OP_MUL, 8'h40, "2 * 0.5");
        add_row(8'hC0, 8'h60, OP_MUL, 8'hA0, "-1 * 2");
        add_row(8'h50, 8'h50, OP_MUL, 8'h62, "1.5 * 1.5");
        add_row(8'h7C, 8'h7C, OP_MUL, 8'h7F, "16 * 16 to maxpos");
        add_row(8'h01, 8'h01, OP_MUL, 8'h01, "minpos squared");
        add_row(8'h80, 8'h40, OP_ADD, 8'h80, "NaR + 1");
        add_row(8'h00, 8'h80, OP_MUL, 8'h80, "0 * NaR");
        add_row(8'h50, 8'h00, OP_MUL, 8'h00, "1.5 * 0");
        add_row(8'h00, 8'h30, OP_ADD, 8'h30, "0 + 0.75");
        add_row(8'h00, 8'h40, OP_SUB, 8'hC0, "0 - 1");
        add_row(8'hA0, 8'h00, OP_ADD, 8'hA0, "-2 + 0");
        // 2 + 1/16 is a tie between 0x60 and 0x61.
        add_row(8'h60, 8'h04, OP_ADD, 8'h60, "tie to even down");
        add_row(8'h61, 8'h04, OP_ADD, 8'h62, "tie to even up");
        add_row(8'h70, 8'h0C, OP_ADD, 8'h70, "4 + 0.1875 down");
        add_row(8'h70, 8'h18, OP_ADD, 8'h71, "4 + 0.375 up");
        add_row(8'h9F, 8'hFC, OP_ADD, 8'h9E, "negative tie up");
        add_row(8'h42, 8'h42, OP_MUL, 8'h44, "product round down");
        add_row(8'h47, 8'h47, OP_MUL, 8'h50, "product round up");
    endtask

    // Any operation with a NaR operand gives NaR.
    task automatic add_nar_rows();
        logic [31:0] r;
        ppu_op_e     o;
        int          i;
        for (i = 0; i < NAR_ROWS; i++) begin
            r = $random(seed);
            case (r[9:8])
                2'd0:    o = OP_ADD;
                2'd1:    o = OP_SUB;
                default: o = OP_MUL;
            endcase
            if (r[10]) begin
                add_row(NAR, r[7:0], o, NAR, "NaR first, random");
            end else begin
                add_row(r[7:0], NAR, o, NAR, "NaR second, random");
            end
        end
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    initial begin
        int i;
        seed     = 32'h27c8bc53;
        reset    = 1'b1;
        p1       = '0;
        p2       = '0;
        op       = OP_ADD;
        in_valid = 1'b0;
        build_table();
        add_nar_rows();

        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (!out_valid && pout == '0) else begin
            $display("Outputs were not cleared by reset at %0t", $time);
            other_errors++;
        end

        // One entry per cycle, back to back.
        for (i = 0; i < num_rows; i++) begin
            @(posedge clk);
            #2;
            p1       = tab_p1[i];
            p2       = tab_p2[i];
            op       = tab_op[i];
            in_valid = 1'b1;
            exp_q.push_back(tab_exp[i]);
            row_q.push_back(i);
            cycle_q.push_back(cycle);
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        p1       = '0;
        p2       = '0;

        wait (results_seen == num_rows);
        repeat (LATENCY + 2) @(posedge clk);
        assert (results_seen == num_rows) else begin
            $display("Got %0d results for %0d table entries", results_seen, num_rows);
            other_errors++;
        end

        $display("%0d tests, %0d passed, %0d failed, %0d other errors",
                 num_rows, tests_passed, tests_failed, other_errors);
        if (tests_failed == 0 && other_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ----------------------------------------
    // Result checking
    // ----------------------------------------

    always @(negedge clk) begin
        if (!reset && out_valid) begin
            results_seen++;
            if (exp_q.size() == 0) begin
                $display("A result appeared at %0t with no operation in flight", $time);
                other_errors++;
            end else begin
                exp_val  = exp_q.pop_front();
                row_idx  = row_q.pop_front();
                in_cycle = cycle_q.pop_front();
                row_ok   = 1'b1;
                assert (pout == exp_val) else begin
                    $display("Error at %0t: pout expected 0x%02h, got 0x%02h",
                             $time, exp_val, pout);
                    row_ok = 1'b0;
                end
                assert (cycle - in_cycle == LATENCY) else begin
                    $display("Error at %0t: out_valid latency expected %0d, got %0d",
                             $time, LATENCY, cycle - in_cycle);
                    row_ok = 1'b0;
                end
                if (row_ok) begin
                    tests_passed++;
                    $display("test %0d %s (%s %02h %02h): ok", row_idx, tab_name[row_idx],
                             tab_op[row_idx].name(), tab_p1[row_idx], tab_p2[row_idx]);
                end else begin
                    tests_failed++;
                    $display("test %0d %s (%s %02h %02h): wrong", row_idx, tab_name[row_idx],
                             tab_op[row_idx].name(), tab_p1[row_idx], tab_p2[row_idx]);
                end
            end
        end
    end

    // Table length plus reset plus slack.
    initial begin
        #1;
        repeat (RESET_CYCLES + num_rows + 20) @(posedge clk);
        $display("Timeout: only %0d of %0d results arrived", results_seen, num_rows);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- ppu_core.sv
// Pipelined posit processing unit

`timescale 1ns/1ps

module ppu_core import ppu_pkg::*; #(
    parameter int N  = 8,
    parameter int ES = 0
) (
    input  logic         clk,
    input  logic         reset,
    input  logic [N-1:0] p1,
    input  logic [N-1:0] p2,
    input  ppu_op_e      op,
    input  logic         in_valid,
    output logic [N-1:0] pout,
    output logic         out_valid
);

    localparam int TE_W = te_size(N, ES);
    localparam int FF   = frac_full_size(N, ES);

    // Operand conditioning and bypass.
    logic [N-1:0]           p1_cond;
    logic [N-1:0]           p2_cond;
    logic                   special;
    logic [N-1:0]           special_value;
    logic                   valid_x;

    // ----------------------------------------
    // Stage 1 decode
    // ----------------------------------------
    logic                   sign1;
    logic                   sign2;
    logic signed [TE_W-1:0] te1;
    logic signed [TE_W-1:0] te2;
    logic [FF-1:0]          frac1;
    logic [FF-1:0]          frac2;
    ppu_op_e                op_d;

    // ----------------------------------------
    // Stage 2 execute
    // ----------------------------------------
    logic                   sign_out;
    logic signed [TE_W-1:0] te_out;
    logic [2*FF-1:0]        frac_out;
    logic                   frac_lsb_cut_off;

    input_conditioning #(.N(N), .ES(ES)) u_input_conditioning (
        .clk(clk), .reset(reset),
        .p1(p1), .p2(p2), .op(op), .in_valid(in_valid),
        .p1_cond(p1_cond), .p2_cond(p2_cond),
        .special(special), .special_value(special_value), .valid_x(valid_x)
    );

    posit_to_fir #(.N(N), .ES(ES)) u_posit_to_fir (
        .clk(clk), .reset(reset),
        .p1_cond(p1_cond), .p2_cond(p2_cond), .op(op),
        .sign1(sign1), .sign2(sign2), .te1(te1), .te2(te2),
        .frac1(frac1), .frac2(frac2), .op_d(op_d)
    );

    fir_ops #(.N(N), .ES(ES)) u_fir_ops (
        .clk(clk), .reset(reset), .op_d(op_d),
        .sign1(sign1), .sign2(sign2), .te1(te1), .te2(te2),
        .frac1(frac1), .frac2(frac2),
        .sign_out(sign_out), .te_out(te_out), .frac_out(frac_out),
        .frac_lsb_cut_off(frac_lsb_cut_off)
    );

    fir_to_posit #(.N(N), .ES(ES)) u_fir_to_posit (
        .clk(clk), .reset(reset),
        .sign_out(sign_out), .te_out(te_out), .frac_out(frac_out),
        .frac_lsb_cut_off(frac_lsb_cut_off),
        .special(special), .special_value(special_value), .valid_x(valid_x),
        .pout(pout), .out_valid(out_valid)
    );

endmodule

//--- fir_to_posit.sv
// Posit round and pack stage

`timescale 1ns/1ps

module fir_to_posit import ppu_pkg::*; #(
    parameter int N  = 8,
    parameter int ES = 0
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    sign_out,
    input  logic signed [te_size(N, ES)-1:0]        te_out,
    input  logic [2*frac_full_size(N, ES)-1:0]      frac_out,
    input  logic                                    frac_lsb_cut_off,
    input  logic                                    special,
    input  logic [N-1:0]                            special_value,
    input  logic                                    valid_x,
    output logic [N-1:0]                            pout,
    output logic                                    out_valid
);

    localparam int TE_W   = te_size(N, ES);
    localparam int FF     = frac_full_size(N, ES);
    localparam int W      = 2 * FF;
    localparam int TAIL_W = ES + W - 1;
    localparam int EW     = TAIL_W + 2 + N;

    localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};

    logic signed [TE_W-1:0] k;
    int                     k_c;
    int                     shamt;
    logic                   r_bit;
    logic [TE_W-1:0]        te_low;
    logic [TAIL_W-1:0]      tail;
    logic [EW-1:0]          ext;
    logic [EW-1:0]          ext_sh;
    logic [N-2:0]           body;
    logic [N-2:0]           body_r;
    logic                   guard;
    logic                   sticky;
    logic                   round_up;
    logic [N-1:0]           mag;
    logic [N-1:0]           p_norm;

    // ----------------------------------------
    // Regime, exponent and fraction string
    // ----------------------------------------

    always_comb begin
        k = te_out >>> ES;
        // Clamp so large values stop at maxpos and tiny ones at minpos.
        if (k > N - 2) begin
            k_c = N - 2;
        end else if (k < -(N - 1)) begin
            k_c = -(N - 1);
        end else begin
            k_c = int'(k);
        end
        r_bit  = (k_c >= 0);
        shamt  = r_bit ? k_c : -k_c - 1;
        te_low = te_out & ~({TE_W{1'b1}} << ES);
        tail   = (TAIL_W'(te_low) << (W - 1)) | TAIL_W'(frac_out[W-2:0]);
        ext    = {r_bit, ~r_bit, tail, {N{1'b0}}};
        // Sign fill stretches the regime run.
        ext_sh = $signed(ext) >>> shamt;

        // ----------------------------------------
        // Round to nearest even
        // ----------------------------------------
        body     = ext_sh[EW-1 -: N-1];
        guard    = ext_sh[EW-N];
        sticky   = (|ext_sh[EW-N-1:0]) | frac_lsb_cut_off;
        round_up = guard & (body[0] | sticky);
        body_r   = body + (N-1)'(round_up);
        if (body_r == '0) begin
            body_r = (N-1)'(1);
        end
        mag = {1'b0, body_r};

        if (frac_out == '0) begin
            p_norm = '0;
        end else begin
            p_norm = sign_out ? -mag : mag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pout      <= '0;
            out_valid <= 1'b0;
        end else begin
            pout      <= special ? special_value : p_norm;
            out_valid <= valid_x;
        end
    end

    // Nonzero sums and products stay clear of zero and NaR.
    a_saturate: assert property (@(posedge clk) disable iff (reset)
        (valid_x && !special && frac_out != '0) |=> (pout != '0 && pout != NAR));

endmodule

//--- fir_ops.sv
// Execute stage for add and multiply

`timescale 1ns/1ps

module fir_ops import ppu_pkg::*; #(
    parameter int N  = 8,
    parameter int ES = 0
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  ppu_op_e                                 op_d,
    input  logic                                    sign1,
    input  logic                                    sign2,
    input  logic signed [te_size(N, ES)-1:0]        te1,
    input  logic signed [te_size(N, ES)-1:0]        te2,
    input  logic [frac_full_size(N, ES)-1:0]        frac1,
    input  logic [frac_full_size(N, ES)-1:0]        frac2,
    output logic                                    sign_out,
    output logic signed [te_size(N, ES)-1:0]        te_out,
    output logic [2*frac_full_size(N, ES)-1:0]      frac_out,
    output logic                                    frac_lsb_cut_off
);

    localparam int TE_W = te_size(N, ES);
    localparam int FF   = frac_full_size(N, ES);
    localparam int W    = 2 * FF;

    logic                   big1;
    logic signed [TE_W-1:0] te_b;
    logic [FF-1:0]          frac_b;
    logic [FF-1:0]          frac_s;
    logic [TE_W-1:0]        diff;
    logic [W-1:0]           ma;
    logic [W-1:0]           mb_full;
    logic [W-1:0]           mb;
    logic [W-1:0]           lost;
    logic                   sticky_a;
    logic [W:0]             sum;
    logic [W:0]             sum_n;
    logic [W-1:0]           prod;
    int                     lz;
    int                     i;
    logic                   sign_c;
    logic signed [TE_W-1:0] te_c;
    logic [W-1:0]           frac_c;
    logic                   sticky_c;

    // ----------------------------------------
    // Alignment, add and normalize
    // ----------------------------------------

    always_comb begin
        big1    = (te1 > te2) || ((te1 == te2) && (frac1 >= frac2));
        te_b    = big1 ? te1 : te2;
        frac_b  = big1 ? frac1 : frac2;
        frac_s  = big1 ? frac2 : frac1;
        diff    = big1 ? te1 - te2 : te2 - te1;
        ma      = {frac_b, {FF{1'b0}}};
        mb_full = {frac_s, {FF{1'b0}}};
        if (diff >= W) begin
            mb       = '0;
            lost     = mb_full;
            sticky_a = |frac_s;
        end else begin
            mb       = mb_full >> diff;
            lost     = mb_full & ~({W{1'b1}} << diff);
            sticky_a = |lost;
        end
        // Borrow one LSB when the shifted-out bits were nonzero.
        if (sign1 == sign2) begin
            sum = {1'b0, ma} + {1'b0, mb};
        end else begin
            sum = {1'b0, ma} - {1'b0, mb} - (W+1)'(sticky_a);
        end
        lz = W + 1;
        for (i = 0; i <= W; i++) begin
            if (sum[i]) begin
                lz = W - i;
            end
        end
        sum_n = sum << lz;
        prod  = frac1 * frac2;

        case (op_d)
            OP_MUL: begin
                sign_c   = sign1 ^ sign2;
                te_c     = TE_W'(int'(te1) + int'(te2) + int'(prod[W-1]));
                frac_c   = prod[W-1] ? prod : prod << 1;
                sticky_c = 1'b0;
            end
            default: begin
                sign_c   = big1 ? sign1 : sign2;
                te_c     = TE_W'(int'(te_b) + 1 - lz);
                frac_c   = sum_n[W:1];
                sticky_c = sticky_a | sum_n[0];
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sign_out         <= 1'b0;
            te_out           <= '0;
            frac_out         <= '0;
            frac_lsb_cut_off <= 1'b0;
        end else begin
            sign_out         <= sign_c;
            te_out           <= te_c;
            frac_out         <= frac_c;
            frac_lsb_cut_off <= sticky_c;
        end
    end

    a_no_sub: assert property (@(posedge clk) disable iff (reset) op_d != OP_SUB);

endmodule

//--- posit_to_fir.sv
// Posit decode stage

`timescale 1ns/1ps

module posit_to_fir import ppu_pkg::*; #(
    parameter int N  = 8,
    parameter int ES = 0
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [N-1:0]                            p1_cond,
    input  logic [N-1:0]                            p2_cond,
    input  ppu_op_e                                 op,
    output logic                                    sign1,
    output logic                                    sign2,
    output logic signed [te_size(N, ES)-1:0]        te1,
    output logic signed [te_size(N, ES)-1:0]        te2,
    output logic [frac_full_size(N, ES)-1:0]        frac1,
    output logic [frac_full_size(N, ES)-1:0]        frac2,
    output ppu_op_e                                 op_d
);

    localparam int TE_W   = te_size(N, ES);
    localparam int FF     = frac_full_size(N, ES);
    localparam int FIR_W  = fir_size(N, ES);
    localparam int FRAC_W = FF - 1;

    logic [FIR_W-1:0] fir1;
    logic [FIR_W-1:0] fir2;

    // Unpack one posit into {sign, te, 1.frac}.
    function automatic logic [FIR_W-1:0] decode(input logic [N-1:0] p);
        logic            s;
        logic [N-1:0]    mag;
        logic [N-2:0]    body;
        logic [N-2:0]    rem;
        logic [N-2:0]    fbits;
        logic            r;
        logic            done;
        int              run;
        int              k;
        int              e;
        int              i;
        logic [TE_W-1:0] te_v;
        logic [FF-1:0]   frac_v;
        s    = p[N-1];
        mag  = s ? -p : p;
        body = mag[N-2:0];
        r    = body[N-2];
        run  = 0;
        done = 1'b0;
        // Length of the regime run.
        for (i = N - 2; i >= 0; i--) begin
            if (!done && body[i] == r) begin
                run++;
            end else begin
                done = 1'b1;
            end
        end
        k      = r ? run - 1 : -run;
        rem    = body << (run + 1);
        e      = int'(rem >> (N - 1 - ES));
        fbits  = rem << ES;
        frac_v = {1'b1, FRAC_W'(fbits >> (ES + 2))};
        te_v   = TE_W'(k * (1 << ES) + e);
        return {s, te_v, frac_v};
    endfunction

    assign fir1 = decode(p1_cond);
    assign fir2 = decode(p2_cond);

    always_ff @(posedge clk) begin
        if (reset) begin
            sign1 <= 1'b0;
            sign2 <= 1'b0;
            te1   <= '0;
            te2   <= '0;
            frac1 <= '0;
            frac2 <= '0;
            op_d  <= OP_ADD;
        end else begin
            sign1 <= fir1[FIR_W-1];
            sign2 <= fir2[FIR_W-1];
            te1   <= fir1[FIR_W-2 -: TE_W];
            te2   <= fir2[FIR_W-2 -: TE_W];
            frac1 <= fir1[FF-1:0];
            frac2 <= fir2[FF-1:0];
            // Operand two is already negated for a subtraction.
            op_d  <= (op == OP_SUB) ? OP_ADD : op;
        end
    end

endmodule

//--- input_conditioning.sv
// Zero and NaR bypass path

`timescale 1ns/1ps

module input_conditioning import ppu_pkg::*; #(
    parameter int N  = 8,
    parameter int ES = 0
) (
    input  logic         clk,
    input  logic         reset,
    input  logic [N-1:0] p1,
    input  logic [N-1:0] p2,
    input  ppu_op_e      op,
    input  logic         in_valid,
    output logic [N-1:0] p1_cond,
    output logic [N-1:0] p2_cond,
    output logic         special,
    output logic [N-1:0] special_value,
    output logic         valid_x
);

    localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};

    logic         any_nar;
    logic         p1_zero;
    logic         p2_zero;
    logic         spec_c;
    logic [N-1:0] spec_val_c;
    logic         spec_q;
    logic [N-1:0] spec_val_q;
    logic         valid_q;

    // Subtraction becomes addition of the negated second operand.
    assign p1_cond = p1;
    assign p2_cond = (op == OP_SUB) ? -p2 : p2;

    assign any_nar = (p1 == NAR) || (p2 == NAR);
    assign p1_zero = (p1 == '0);
    assign p2_zero = (p2 == '0);

    always_comb begin
        spec_c     = 1'b1;
        spec_val_c = '0;
        if (any_nar) begin
            spec_val_c = NAR;
        end else if (op == OP_MUL) begin
            spec_c = p1_zero || p2_zero;
        end else if (p1_zero) begin
            spec_val_c = p2_cond;
        end else if (p2_zero) begin
            spec_val_c = p1_cond;
        end else begin
            spec_c = 1'b0;
        end
    end

    // Two stages, matching decode and execute.
    always_ff @(posedge clk) begin
        if (reset) begin
            spec_q        <= 1'b0;
            spec_val_q    <= '0;
            valid_q       <= 1'b0;
            special       <= 1'b0;
            special_value <= '0;
            valid_x       <= 1'b0;
        end else begin
            spec_q        <= spec_c;
            spec_val_q    <= spec_val_c;
            valid_q       <= in_valid;
            special       <= spec_q;
            special_value <= spec_val_q;
            valid_x       <= valid_q;
        end
    end

    a_nar_bypass: assert property (@(posedge clk) disable iff (reset)
        ((p1 == NAR) || (p2 == NAR)) |-> ##2 (special && special_value == NAR));

endmodule

//--- ppu_pkg.sv
// Posit unit shared definitions

package ppu_pkg;

    // ----------------------------------------
    // Opcodes
    // ----------------------------------------

    localparam int OP_SIZE = 2;

    typedef enum logic [OP_SIZE-1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } ppu_op_e;

    // ----------------------------------------
    // Internal format widths
    // ----------------------------------------

    // Signed total exponent, regime * 2^es + exp, with one spare bit.
    function automatic int te_size(input int n, input int es);
        return $clog2(n) + es + 2;
    endfunction

    // Fraction with the hidden bit.
    // Longest fraction field is n - 3 - es bits.
    function automatic int frac_full_size(input int n, input int es);
        return n - es - 2;
    endfunction

    // One unpacked operand: sign, total exponent, fraction.
    function automatic int fir_size(input int n, input int es);
        return 1 + te_size(n, es) + frac_full_size(n, es);
    endfunction

endpackage
